/* vlog.f */
+incdir+hw
hw/calc_pkg.sv
hw/keypad_scanner.sv
hw/calc_control.sv
hw/arith_unit.sv
hw/bin_to_bcd.sv
hw/display_mux.sv
hw/calc_top.sv
verification/calc_tb.sv

/* Makefile */
# Verilator build and run for the keypad calculator

VERILATOR ?= verilator
TOP       ?= calc_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_TEXT ?= ERRORS FOUND
PASS_TEXT ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/calc_settings.svh

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Test failed"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "Test did not complete"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/calc_tb.sv */
// Keypad calculator testbench
`include "calc_settings.svh"

module calc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import calc_pkg::*;

    localparam int SCAN_CLKS    = 4 * `CALC_SCAN_DIV;   // One full keypad scan
    localparam int PRESS_CLKS   = (`CALC_KEY_STABLE + 2) * SCAN_CLKS;
    localparam int RELEASE_CLKS = 2 * SCAN_CLKS;
    localparam int ROUND_CLKS   = 4 * `CALC_REFRESH_DIV;
    // Worst multiply of 99 additions plus the BCD conversion
    localparam int CALC_CLKS    = 100 + `CALC_RESULT_W + 1 + 8;
    localparam int POLL_ROUNDS  = CALC_CLKS / ROUND_CLKS + 2;
    localparam int NUM_PRESSES  = 96;   // All key presses over the directed tests
    localparam int NUM_CALCS    = 12;   // Equals presses
    localparam int WATCHDOG_CLKS = 2 * (NUM_PRESSES * (PRESS_CLKS + RELEASE_CLKS)
                                        + NUM_CALCS * CALC_CLKS) + 1000;

    // Position is row * 4 + column
    localparam key_code_t PAD_MAP [0:15] = '{
        K1,    K2, K3,    KEY_ADD,
        K4,    K5, K6,    KEY_MUL,
        K7,    K8, K9,    KEY_EQ,
        KEY_E, K0, KEY_F, KEY_CLR
    };

    logic        clk;
    logic        rst;
    logic [3:0]  cols;
    logic [3:0]  rows;
    logic [6:0]  seg;
    logic [3:0]  an;
    logic [15:0] lfsr;

    calc_top dut0 (
        .clk(clk), .rst(rst), .cols(cols), .rows(rows), .seg(seg), .an(an)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ********************
    // Reporting
    // ********************
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input logic [15:0] got,
                         input logic [15:0] expected);
        if (got !== expected)
            fail_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected));
    endtask

    // ********************
    // Reference models
    // ********************
    // Active-low hex table with bit 4 set for unknown patterns
    function automatic logic [4:0] seg_to_hex(input logic [6:0] s);
        case (s)
            7'b1000000: return 5'h00;
            7'b1111001: return 5'h01;
            7'b0100100: return 5'h02;
            7'b0110000: return 5'h03;
            7'b0011001: return 5'h04;
            7'b0010010: return 5'h05;
            7'b0000010: return 5'h06;
            7'b1111000: return 5'h07;
            7'b0000000: return 5'h08;
            7'b0011000: return 5'h09;
            7'b0001000: return 5'h0A;
            7'b0000011: return 5'h0B;
            7'b1000110: return 5'h0C;
            7'b0100001: return 5'h0D;
            7'b0000110: return 5'h0E;
            7'b0001110: return 5'h0F;
            default:    return 5'h10;
        endcase
    endfunction

    function automatic logic [15:0] to_bcd(input int value);
        logic [15:0] bcd;
        int          rest;
        rest = value;
        for (int d = 0; d < 4; d++) begin
            bcd[4*d +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return bcd;
    endfunction

    // Fibonacci LFSR on x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    // ********************
    // Keypad and display
    // ********************
    task automatic press_key(input key_code_t code);
        int pos;
        pos = 0;
        for (int i = 0; i < 16; i++) begin
            if (PAD_MAP[i] == code)
                pos = i;
        end
        repeat (PRESS_CLKS) begin
            @(negedge clk);
            cols = rows[pos / 4] ? 4'(1 << (pos % 4)) : 4'b0000;   // Column follows its row
        end
        @(negedge clk);
        cols = 4'b0000;
        repeat (RELEASE_CLKS) @(negedge clk);
    endtask

    task automatic read_display(output logic [15:0] value);
        logic [4:0] dec;
        for (int d = 0; d < 4; d++) begin
            @(negedge clk);
            while (an != ~(4'b0001 << d))
                @(negedge clk);
            dec = seg_to_hex(seg);
            if (dec[4])
                fail_run($sformatf("Unknown segment pattern %b on digit %0d", seg, d));
            value[4*d +: 4] = dec[3:0];
        end
    endtask

    // Reads again until the value settles or the bound runs out
    task automatic expect_display(input string name, input logic [15:0] expected);
        logic [15:0] shown;
        int          rounds;
        rounds = 0;
        read_display(shown);
        while (shown !== expected && rounds < POLL_ROUNDS) begin
            read_display(shown);
            rounds++;
        end
        check(name, shown, expected);
    endtask

    task automatic enter_operation(input int a, input bit mul, input int b);
        press_key(key_code_t'(a / 10));
        press_key(key_code_t'(a % 10));
        press_key(mul ? KEY_MUL : KEY_ADD);
        press_key(key_code_t'(b / 10));
        press_key(key_code_t'(b % 10));
        press_key(KEY_EQ);
    endtask

    // ********************
    // Directed tests
    // ********************
    task automatic reset_shows_zero();
        check("rows after reset", 16'(rows), 16'h0001);
        check("an after reset", 16'(an), 16'h000E);
        expect_display("display after reset", 16'h0000);
    endtask

    task automatic entry_updates_display();
        press_key(K4);
        press_key(K7);
        expect_display("first operand", 16'h0047);
        press_key(KEY_E);                                  // No function
        expect_display("display after key E", 16'h0047);
        press_key(KEY_ADD);
        expect_display("display after operator", 16'h0047);
        press_key(K3);
        press_key(K8);
        expect_display("second operand", 16'h0038);
    endtask

    task automatic addition_result();
        press_key(KEY_CLR);
        enter_operation(47, 1'b0, 38);
        expect_display("sum 47 + 38", to_bcd(47 + 38));
    endtask

    task automatic multiply_results();
        press_key(KEY_CLR);
        enter_operation(99, 1'b1, 99);
        expect_display("product 99 * 99", to_bcd(99 * 99));
        press_key(KEY_CLR);
        enter_operation(12, 1'b1, 0);                      // Zero multiplier
        expect_display("product 12 * 0", to_bcd(0));
    endtask

    task automatic clear_and_restart();
        press_key(KEY_CLR);
        press_key(K4);
        press_key(K7);
        press_key(KEY_ADD);
        press_key(K3);
        expect_display("tens of second operand", 16'h0003);
        press_key(KEY_CLR);
        expect_display("display after clear", 16'h0000);
        enter_operation(25, 1'b1, 14);
        expect_display("product 25 * 14", to_bcd(25 * 14));
        press_key(K5);                                     // Ignored while showing
        expect_display("result after digit in SHOW", to_bcd(25 * 14));
    endtask

    task automatic random_operations();
        int a;
        int b;
        bit mul;
        for (int n = 0; n < 8; n++) begin
            a   = random_bits(7) % 100;
            b   = random_bits(7) % 100;
            mul = random_bits(1) != 0;
            press_key(KEY_CLR);
            enter_operation(a, mul, b);
            expect_display($sformatf("result of %0d %s %0d", a, mul ? "*" : "+", b),
                           to_bcd(mul ? a * b : a + b));
        end
    endtask

    initial begin
        rst  = 1'b1;
        cols = 4'b0000;
        lfsr = 16'd28;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_shows_zero();
        entry_updates_display();
        addition_result();
        multiply_results();
        clear_and_restart();
        random_operations();
        $display("NO ERRORS");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        fail_run($sformatf("Timeout: tests did not finish within %0d clocks", WATCHDOG_CLKS));
    end

endmodule

/* hw/calc_top.sv */
// Keypad calculator top level
`include "calc_settings.svh"

module calc_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] cols,
    output logic [3:0] rows,
    output logic [6:0] seg,
    output logic [3:0] an
);
    import calc_pkg::*;

    key_event_t                key;
    operands_t                 opnds;
    logic                      arith_start;
    logic [`CALC_RESULT_W-1:0] arith_result;
    logic                      arith_done;
    logic                      bcd_start;
    logic [`CALC_RESULT_W-1:0] bcd_in;
    logic [`CALC_RESULT_W-1:0] bcd_out;
    logic                      bcd_done;
    logic [`CALC_RESULT_W-1:0] disp_value;

    keypad_scanner u_scan (
        .clk(clk), .rst(rst), .cols(cols), .rows(rows), .key(key)
    );

    calc_control u_ctrl (
        .clk(clk), .rst(rst), .key(key), .opnds(opnds),
        .arith_start(arith_start), .arith_result(arith_result), .arith_done(arith_done),
        .bcd_start(bcd_start), .bcd_in(bcd_in), .bcd_done(bcd_done), .bcd_out(bcd_out),
        .disp_value(disp_value)
    );

    arith_unit u_arith (
        .clk(clk), .rst(rst), .opnds(opnds), .arith_start(arith_start),
        .arith_result(arith_result), .arith_done(arith_done)
    );

    bin_to_bcd u_bcd (
        .clk(clk), .rst(rst), .bcd_start(bcd_start), .bcd_in(bcd_in),
        .bcd_out(bcd_out), .bcd_done(bcd_done)
    );

    // Display refresh
    display_mux u_disp (
        .clk(clk), .rst(rst), .disp_value(disp_value), .seg(seg), .an(an)
    );

endmodule

/* hw/display_mux.sv */
// Seven-segment display multiplexer
`include "calc_settings.svh"

module display_mux (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CALC_RESULT_W-1:0] disp_value,
    output logic [6:0]                seg,
    output logic [3:0]                an
);
    localparam int REF_W = $clog2(`CALC_REFRESH_DIV + 1);

    logic [REF_W-1:0]         ref_cnt;
    logic [1:0]               digit_idx;
    logic [`CALC_DIGIT_W-1:0] nibble;

    // Refresh timing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ref_cnt   <= '0;
            digit_idx <= 2'd0;
        end else if (ref_cnt == REF_W'(`CALC_REFRESH_DIV - 1)) begin
            ref_cnt   <= '0;
            digit_idx <= digit_idx + 1'b1;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    assign nibble = disp_value[digit_idx*`CALC_DIGIT_W +: `CALC_DIGIT_W];
    assign an     = ~(4'b0001 << digit_idx);   // Active low

    // ********************
    // Hex decode, segments active low
    // ********************
    always_comb begin
        case (nibble)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0011000;
            4'hA:    seg = 7'b0001000;
            4'hB:    seg = 7'b0000011;
            4'hC:    seg = 7'b1000110;
            4'hD:    seg = 7'b0100001;
            4'hE:    seg = 7'b0000110;
            default: seg = 7'b0001110;   // F
        endcase
    end

    one_anode: assert property (@(posedge clk) disable iff (rst) $onehot(~an));

endmodule

/* hw/bin_to_bcd.sv */
// Binary to BCD converter
`include "calc_settings.svh"

module bin_to_bcd (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      bcd_start,
    input  logic [`CALC_RESULT_W-1:0] bcd_in,
    output logic [`CALC_RESULT_W-1:0] bcd_out,
    output logic                      bcd_done
);
    localparam int W      = `CALC_RESULT_W;
    localparam int STEP_W = $clog2(W + 1);

    logic [2*W-1:0]    shift_reg;   // BCD half on top, binary below
    logic [2*W-1:0]    shift_nxt;
    logic [STEP_W-1:0] step_cnt;
    logic              busy;

    // One double-dabble step
    always_comb begin
        shift_nxt = shift_reg;
        for (int j = 0; j < W / 4; j++) begin
            if (shift_nxt[W + 4*j +: 4] >= 4'd5)
                shift_nxt[W + 4*j +: 4] = shift_nxt[W + 4*j +: 4] + 4'd3;
        end
        shift_nxt = shift_nxt << 1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            bcd_done <= 1'b0;
        end else begin
            bcd_done <= 1'b0;
            if (bcd_start) begin
                busy     <= 1'b1;
                step_cnt <= STEP_W'(W);
            end else if (busy) begin
                step_cnt <= step_cnt - 1'b1;
                if (step_cnt == STEP_W'(1)) begin   // Last shift this cycle
                    busy     <= 1'b0;
                    bcd_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bcd_start)
            shift_reg <= {{W{1'b0}}, bcd_in};
        else if (busy)
            shift_reg <= shift_nxt;
        if (busy && step_cnt == STEP_W'(1))
            bcd_out <= shift_nxt[2*W-1:W];
    end

endmodule

/* hw/arith_unit.sv */
// Adder and repeated-add multiplier
`include "calc_settings.svh"

module arith_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  calc_pkg::operands_t       opnds,
    input  logic                      arith_start,
    output logic [`CALC_RESULT_W-1:0] arith_result,
    output logic                      arith_done
);
    import calc_pkg::*;

    localparam int RES_W = `CALC_RESULT_W;

    logic [`CALC_OPND_W-1:0] mcand;   // Operand a, added each step
    logic [`CALC_OPND_W-1:0] count;   // Additions still to go
    logic                    busy;

    // Control. A zero multiplier or an add finishes right away
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            count      <= '0;
            arith_done <= 1'b0;
        end else begin
            arith_done <= 1'b0;
            if (arith_start) begin
                if (opnds.op == OP_MUL && opnds.b != '0) begin
                    busy  <= 1'b1;
                    count <= opnds.b - 1'b1;   // First addition happens on start
                end else begin
                    arith_done <= 1'b1;
                end
            end else if (busy) begin
                if (count == '0) begin
                    busy       <= 1'b0;
                    arith_done <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (arith_start) begin
            mcand <= opnds.a;
            if (opnds.op == OP_ADD)
                arith_result <= RES_W'(opnds.a) + RES_W'(opnds.b);
            else if (opnds.b == '0)
                arith_result <= '0;
            else
                arith_result <= RES_W'(opnds.a);
        end else if (busy && count != '0) begin
            arith_result <= arith_result + RES_W'(mcand);
        end
    end

    done_not_start: assert property (@(posedge clk) disable iff (rst)
        !(arith_start && arith_done));

endmodule

/* hw/calc_control.sv */
// Calculator entry and sequencing
`include "calc_settings.svh"

module calc_control (
    input  logic                      clk,
    input  logic                      rst,
    input  calc_pkg::key_event_t      key,
    output calc_pkg::operands_t       opnds,
    output logic                      arith_start,
    input  logic [`CALC_RESULT_W-1:0] arith_result,
    input  logic                      arith_done,
    output logic                      bcd_start,
    output logic [`CALC_RESULT_W-1:0] bcd_in,
    input  logic                      bcd_done,
    input  logic [`CALC_RESULT_W-1:0] bcd_out,
    output logic [`CALC_RESULT_W-1:0] disp_value
);
    import calc_pkg::*;

    localparam int OPND_W = `CALC_OPND_W;
    localparam int RES_W  = `CALC_RESULT_W;

    ctrl_state_t              state;
    logic [`CALC_DIGIT_W-1:0] tens_digit;
    logic [`CALC_DIGIT_W-1:0] digit;
    logic                     b_full;       // Second operand complete, equals allowed
    logic                     is_digit;
    logic                     is_clear;
    logic                     is_eq;
    logic [OPND_W-1:0]        typed_opnd;

    assign digit      = key.code;
    assign is_digit   = key.valid && (key.code <= K9);
    assign is_clear   = key.valid && (key.code == KEY_CLR);
    assign is_eq      = key.valid && (key.code == KEY_EQ);

    // Tens times ten plus units
    assign typed_opnd = OPND_W'(tens_digit) * OPND_W'(10) + OPND_W'(digit);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= A_TENS;
            opnds       <= '0;
            tens_digit  <= '0;
            b_full      <= 1'b0;
            arith_start <= 1'b0;
            bcd_start   <= 1'b0;
            bcd_in      <= '0;
            disp_value  <= '0;
        end else begin
            arith_start <= 1'b0;
            bcd_start   <= 1'b0;
            if (is_clear && state != CALC && state != CONVERT) begin
                state      <= A_TENS;
                opnds      <= '0;
                b_full     <= 1'b0;
                disp_value <= '0;
            end else begin
                case (state)
                    A_TENS, B_TENS: begin
                        if (is_digit) begin
                            tens_digit <= digit;
                            disp_value <= RES_W'(digit);
                            state      <= (state == A_TENS) ? A_UNITS : B_UNITS;
                        end
                    end
                    A_UNITS: begin
                        if (is_digit) begin
                            opnds.a    <= typed_opnd;
                            disp_value <= RES_W'({tens_digit, digit});
                            state      <= OPER;
                        end
                    end
                    OPER: begin   // Display keeps the first operand
                        if (key.valid && key.code == KEY_ADD) begin
                            opnds.op <= OP_ADD;
                            state    <= B_TENS;
                        end else if (key.valid && key.code == KEY_MUL) begin
                            opnds.op <= OP_MUL;
                            state    <= B_TENS;
                        end
                    end
                    B_UNITS: begin
                        if (is_digit && !b_full) begin
                            opnds.b    <= typed_opnd;
                            b_full     <= 1'b1;
                            disp_value <= RES_W'({tens_digit, digit});
                        end else if (is_eq && b_full) begin
                            arith_start <= 1'b1;
                            state       <= CALC;
                        end
                    end
                    CALC: begin
                        if (arith_done) begin
                            bcd_in    <= arith_result;
                            bcd_start <= 1'b1;
                            state     <= CONVERT;
                        end
                    end
                    CONVERT: begin
                        if (bcd_done) begin
                            disp_value <= bcd_out;
                            state      <= SHOW;
                        end
                    end
                    default: state <= state;   // SHOW waits for clear
                endcase
            end
        end
    end

    starts_apart: assert property (@(posedge clk) disable iff (rst)
        !(arith_start && bcd_start));

endmodule

/* hw/keypad_scanner.sv */
// Keypad scanner and debounce
`include "calc_settings.svh"

module keypad_scanner (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [3:0]           cols,
    output logic [3:0]           rows,
    output calc_pkg::key_event_t key
);
    import calc_pkg::*;

    localparam int SCAN_W   = $clog2(`CALC_SCAN_DIV + 1);
    localparam int STABLE_W = $clog2(`CALC_KEY_STABLE + 1);

    // Indexed by {row, column}, first hit in column order wins
    localparam key_code_t KEY_MAP [0:15] = '{
        K1,    K2, K3,    KEY_ADD,
        K4,    K5, K6,    KEY_MUL,
        K7,    K8, K9,    KEY_EQ,
        KEY_E, K0, KEY_F, KEY_CLR
    };

    logic [SCAN_W-1:0]   scan_cnt;
    logic                row_tick;
    logic [1:0]          row_idx;
    logic [1:0]          col_idx;
    logic                row_hit;
    key_code_t           row_code;
    logic                scan_hit;     // Any column seen so far in this scan
    key_code_t           scan_code;
    logic                hit_now;
    key_code_t           code_now;
    key_code_t           last_code;    // Candidate of the previous scan
    logic [STABLE_W-1:0] stable_cnt;
    logic [STABLE_W-1:0] stable_nxt;
    logic                released;     // Keypad seen empty since last accept

    // ********************
    // Row drive
    // ********************
    assign row_tick = (scan_cnt == SCAN_W'(`CALC_SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            rows     <= 4'b0001;
        end else if (row_tick) begin
            scan_cnt <= '0;
            rows     <= {rows[2:0], rows[3]};
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        row_idx = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (rows[i])
                row_idx = 2'(i);
        end
    end

    // Lowest column has priority
    always_comb begin
        col_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (cols[i])
                col_idx = 2'(i);
        end
    end

    // ********************
    // Debounce per scan
    // ********************
    assign row_hit  = |cols;
    assign row_code = KEY_MAP[{row_idx, col_idx}];
    assign hit_now  = scan_hit | row_hit;
    assign code_now = scan_hit ? scan_code : row_code;

    always_comb begin
        stable_nxt = stable_cnt;
        if (!hit_now)
            stable_nxt = '0;
        else if (stable_cnt == '0 || code_now != last_code)
            stable_nxt = STABLE_W'(1);   // New candidate starts over
        else if (stable_cnt != STABLE_W'(`CALC_KEY_STABLE))
            stable_nxt = stable_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_hit   <= 1'b0;
            scan_code  <= K0;
            last_code  <= K0;
            stable_cnt <= '0;
            released   <= 1'b1;
            key        <= '0;
        end else begin
            key.valid <= 1'b0;
            if (row_tick) begin
                if (rows[3]) begin   // Last row closes the scan
                    scan_hit   <= 1'b0;
                    last_code  <= code_now;
                    stable_cnt <= stable_nxt;
                    if (!hit_now) begin
                        released <= 1'b1;
                    end else if (released && stable_nxt == STABLE_W'(`CALC_KEY_STABLE)) begin
                        key.valid <= 1'b1;
                        key.code  <= code_now;
                        released  <= 1'b0;
                    end
                end else begin
                    scan_hit  <= hit_now;
                    scan_code <= code_now;
                end
            end
        end
    end

    rows_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(rows));

endmodule

/* hw/calc_pkg.sv */
// Keypad calculator types
`include "calc_settings.svh"

package calc_pkg;

    // Digits carry their own value so they feed the operand math directly
    typedef enum logic [`CALC_DIGIT_W-1:0] {
        K0      = 0,
        K1      = 1,
        K2      = 2,
        K3      = 3,
        K4      = 4,
        K5      = 5,
        K6      = 6,
        K7      = 7,
        K8      = 8,
        K9      = 9,
        KEY_ADD = 10,   // A
        KEY_MUL = 11,   // B
        KEY_EQ  = 12,   // C
        KEY_CLR = 13,   // D
        KEY_E   = 14,   // No function
        KEY_F   = 15    // No function
    } key_code_t;

    typedef enum logic {
        OP_ADD,
        OP_MUL
    } op_t;

    // Entry position, then the compute steps
    typedef enum logic [2:0] {
        A_TENS,
        A_UNITS,
        OPER,
        B_TENS,
        B_UNITS,
        CALC,
        CONVERT,
        SHOW
    } ctrl_state_t;

    typedef struct packed {
        logic      valid;
        key_code_t code;
    } key_event_t;

    typedef struct packed {
        logic [`CALC_OPND_W-1:0] a;
        logic [`CALC_OPND_W-1:0] b;
        op_t                     op;
    } operands_t;

endpackage

/* hw/calc_settings.svh */
// Keypad calculator settings
`ifndef CALC_SETTINGS_SVH
`define CALC_SETTINGS_SVH

// ********************
// Timing counts
// ********************
`define CALC_SCAN_DIV     4   // Clocks per keypad row step
`define CALC_KEY_STABLE   2   // Matching full scans before a key is taken
`define CALC_REFRESH_DIV  3   // Clocks per display digit

// ********************
// Data widths
// ********************
`define CALC_DIGIT_W      4   // One BCD digit or key code
`define CALC_OPND_W       8   // Two-digit operand, 0 to 99
`define CALC_RESULT_W     16  // Product up to 9801, also the BCD word

`endif
